//--- flist.f
src/opfetch_pkg.sv
src/cmd_decode.sv
src/operand_fetch.sv
src/operand_update.sv
src/mem_writeback.sv
src/opfetch_top.sv
verif/tb_mem_model.sv
verif/tb_opfetch.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_opfetch
FLIST = flist.f
OUT   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OUT)

run: compile
	./$(OUT)/V$(TOP)

clean:
	rm -rf $(OUT)

//--- verif/tb_opfetch.sv
`timescale 1ns/1ps

module tb_opfetch;

  import opfetch_pkg::*;

  localparam int n_random = 40;
  localparam int wait_limit = 600;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] ip;
    logic [31:0] dst_value;
  } stim_t;

  typedef struct packed {
    logic [3:0]  reg_num;
    logic [31:0] data;
  } write_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              cmd_valid;
  logic [31:0]       cmd_word;
  logic [31:0]       cmd_ip;
  logic [31:0]       dst_value;
  logic              cmd_ready;
  mem_req_t          mem_req;
  logic [31:0]       rdata;
  logic              read_dn;
  logic              write_dn;
  operands_t         operands;
  logic              ops_valid;
  logic              done;
  logic              load_en;
  logic [3:0]        load_addr;
  logic [31:0]       load_data;
  logic [15:0][31:0] image;

  // reference state
  logic [15:0][31:0] mirror;
  stim_t             pending[$];
  write_t            exp_writes[$];
  operands_t         exp_ops;
  logic              mem_busy = 1'b0;
  int                sent_count = 0;
  int                ops_count = 0;
  int                done_count = 0;

  opfetch_top uut (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .cmd_ip    (cmd_ip),
    .dst_value (dst_value),
    .cmd_ready (cmd_ready),
    .mem_req   (mem_req),
    .rdata     (rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .operands  (operands),
    .ops_valid (ops_valid),
    .done      (done)
  );

  tb_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rdata     (rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .image     (image)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  // expected value of one slot from the mirrored memory
  function automatic logic [31:0] ref_fetch(input logic [3:0] r, input logic p,
                                            input logic [31:0] ip,
                                            output logic [31:0] ea);
    logic [31:0] word0;
    ea = 32'(r);
    if (r == 4'd15) begin
      return ip;
    end
    word0 = mirror[r];
    if (!p) begin
      return word0;
    end
    ea = word0;
    if (word0 == 32'd15) begin
      return ip;
    end
    return mirror[word0[3:0]];
  endfunction

  task automatic queue_op_write(input logic [3:0] r, input logic p, input mode_e m,
                                input logic [31:0] val, input logic [31:0] ea,
                                input logic [3:0] dst_reg, input logic [31:0] new_dst);
    logic [31:0] base;
    write_t      w;
    if (m == mode_inc || m == mode_dec) begin
      // pointer slots step the address and the others step the value
      base = p ? ea : ((r == dst_reg) ? new_dst : val);
      w.reg_num = r;
      w.data = (m == mode_inc) ? base + 32'd1 : base - 32'd1;
      exp_writes.push_back(w);
    end
  endtask

  task automatic predict(input stim_t s);
    logic [31:0] cond_ea;
    logic [31:0] src1_ea;
    logic [31:0] src0_ea;
    logic [31:0] new_dst;
    logic [3:0]  dst_reg;
    mode_e       dst_mode;
    write_t      w;
    dst_reg = s.word[11:8];
    dst_mode = mode_e'(s.word[25:24]);
    exp_ops.cond = ref_fetch(s.word[15:12], s.word[19], s.ip, cond_ea);
    exp_ops.src1 = ref_fetch(s.word[3:0], s.word[16], s.ip, src1_ea);
    exp_ops.src0 = ref_fetch(s.word[7:4], s.word[17], s.ip, src0_ea);
    case (dst_mode)
      mode_inc: new_dst = s.dst_value + 32'd1;
      mode_dec: new_dst = s.dst_value - 32'd1;
      default: new_dst = s.dst_value;
    endcase
    if (dst_mode != mode_keep) begin
      w.reg_num = dst_reg;
      w.data = new_dst;
      exp_writes.push_back(w);
    end
    // write order dst, cond, src1, src0
    queue_op_write(s.word[15:12], s.word[19], mode_e'(s.word[27:26]), exp_ops.cond,
                   cond_ea, dst_reg, new_dst);
    queue_op_write(s.word[3:0], s.word[16], mode_e'(s.word[21:20]), exp_ops.src1,
                   src1_ea, dst_reg, new_dst);
    queue_op_write(s.word[7:4], s.word[17], mode_e'(s.word[23:22]), exp_ops.src0,
                   src0_ea, dst_reg, new_dst);
  endtask

  always @(negedge clk) begin : monitor
    write_t w;
    stim_t  s;
    if (!rst) begin
      // a done strobe frees the port in the same cycle
      if (read_dn || write_dn) begin
        mem_busy = 1'b0;
      end
      if (mem_req.read || mem_req.write) begin
        assert (!mem_busy)
          else stop_run("a memory request came while another one was outstanding");
        mem_busy = 1'b1;
      end
      if (ops_valid) begin
        assert (pending.size() > 0) else stop_run("ops_valid came without a command");
        assert (exp_writes.size() == 0)
          else stop_run("ops_valid came before the previous command finished");
        s = pending.pop_front();
        predict(s);
        assert (operands == exp_ops)
          else stop_run($sformatf("Error at %0t: operands %h, expected %h",
                                  $time, operands, exp_ops));
        ops_count++;
      end
      if (mem_req.write) begin
        assert (exp_writes.size() > 0)
          else stop_run($sformatf("Error at %0t: unexpected write at address %0d",
                                  $time, mem_req.addr));
        w = exp_writes.pop_front();
        assert (mem_req.addr == 32'(w.reg_num) && mem_req.wdata == w.data)
          else stop_run($sformatf("Error at %0t: write %0d <- %h, expected %0d <- %h",
                                  $time, mem_req.addr, mem_req.wdata, w.reg_num, w.data));
        mirror[w.reg_num] = w.data;
      end
      if (done) begin
        assert (done_count < ops_count) else stop_run("done came without a fetched command");
        assert (exp_writes.size() == 0) else stop_run("done came before all writes");
        assert (image == mirror)
          else stop_run($sformatf("Error at %0t: memory %h, expected %h",
                                  $time, image, mirror));
        done_count++;
      end
    end
  end

  task automatic check_idle_outputs(input string when);
    assert (!mem_req.read && !mem_req.write && !ops_valid && !done && !uut.wb_busy
            && !uut.dec_valid && cmd_ready)
      else stop_run($sformatf("Error at %0t: outputs not idle %s", $time, when));
  endtask

  // ptr is {cond, dst, src0, src1}
  function automatic logic [31:0] pack_word(input logic [3:0] cond_r, input logic [3:0] src1_r,
                                            input logic [3:0] src0_r, input logic [3:0] dst_r,
                                            input logic [3:0] ptr, input mode_e cond_m,
                                            input mode_e src1_m, input mode_e src0_m,
                                            input mode_e dst_m);
    return {4'h0, cond_m, dst_m, src0_m, src1_m, ptr, cond_r, dst_r, src0_r, src1_r};
  endfunction

  function automatic stim_t make_stim(input logic [31:0] word, input logic [31:0] ip,
                                      input logic [31:0] dv);
    stim_t s;
    s.word = word;
    s.ip = ip;
    s.dst_value = dv;
    return s;
  endfunction

  function automatic stim_t random_stim();
    stim_t s;
    s.word = $urandom & 32'h0fff_ffff;
    s.ip = 32'h0000_1000 + 32'($urandom_range(255, 0));
    s.dst_value = 32'($urandom_range(15, 0));
    return s;
  endfunction

  task automatic set_word(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    load_en <= 1'b1;
    load_addr <= addr;
    load_data <= data;
    mirror[addr] = data;
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // values stay below 16 so they work as pointers
  task automatic fill_mem(input int k);
    for (int i = 0; i < 16; i++) begin
      set_word(4'(i), 32'((i * 7 + k) % 16));
    end
  endtask

  task automatic send_cmd(input stim_t s);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cmd_ready) begin
      waited++;
      if (waited > wait_limit) begin
        stop_run("Timeout: cmd_ready stayed low");
      end
      @(negedge clk);
    end
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_word <= s.word;
    cmd_ip <= s.ip;
    dst_value <= s.dst_value;
    pending.push_back(s);
    sent_count++;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_all_done();
    int waited;
    waited = 0;
    while (done_count != sent_count) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) begin
        stop_run("Timeout: commands did not finish");
      end
    end
  endtask

  initial begin
    void'($urandom(32'hda0));
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_word = '0;
    cmd_ip = '0;
    dst_value = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    mirror = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_idle_outputs("during reset");
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle_outputs("after reset");

    // direct reads with nothing written back
    fill_mem(3);
    send_cmd(make_stim(pack_word(4'd1, 4'd2, 4'd3, 4'd4, 4'b0000,
                                 mode_keep, mode_keep, mode_keep, mode_keep),
                       32'h400, 32'd9));
    wait_all_done();

    // pointers and ip through register 15 or a pointer value of 15
    set_word(4'd5, 32'd15);
    set_word(4'd6, 32'd9);
    set_word(4'd7, 32'd2);
    send_cmd(make_stim(pack_word(4'd15, 4'd5, 4'd6, 4'd7, 4'b1011,
                                 mode_keep, mode_keep, mode_keep, mode_keep),
                       32'h0a5c, 32'd3));
    send_cmd(make_stim(pack_word(4'd7, 4'd15, 4'd0, 4'd8, 4'b1000,
                                 mode_keep, mode_keep, mode_keep, mode_keep),
                       32'h0b00, 32'd1));
    wait_all_done();

    // dst inc, dec, keep and none
    send_cmd(make_stim(pack_word(4'd1, 4'd2, 4'd3, 4'd8, 4'b0000,
                                 mode_keep, mode_keep, mode_keep, mode_inc), 32'h10, 32'd5));
    send_cmd(make_stim(pack_word(4'd1, 4'd2, 4'd3, 4'd9, 4'b0000,
                                 mode_keep, mode_keep, mode_keep, mode_dec), 32'h20, 32'd0));
    send_cmd(make_stim(pack_word(4'd1, 4'd2, 4'd3, 4'd10, 4'b0000,
                                 mode_keep, mode_keep, mode_keep, mode_keep), 32'h30, 32'd7));
    send_cmd(make_stim(pack_word(4'd1, 4'd2, 4'd3, 4'd11, 4'b0000,
                                 mode_keep, mode_keep, mode_keep, mode_none), 32'h40, 32'd4));
    wait_all_done();

    // operand write-back with aliasing onto dst and pointer bases
    set_word(4'd4, 32'd6);
    send_cmd(make_stim(pack_word(4'd2, 4'd3, 4'd4, 4'd3, 4'b0010,
                                 mode_dec, mode_inc, mode_dec, mode_inc), 32'h50, 32'd10));
    send_cmd(make_stim(pack_word(4'd5, 4'd6, 4'd5, 4'd5, 4'b1010,
                                 mode_inc, mode_dec, mode_inc, mode_none), 32'h60, 32'd7));
    send_cmd(make_stim(pack_word(4'd12, 4'd13, 4'd12, 4'd12, 4'b1001,
                                 mode_inc, mode_inc, mode_dec, mode_dec), 32'h70, 32'd2));
    wait_all_done();

    // random back to back commands
    fill_mem(11);
    for (int n = 0; n < n_random; n++) begin
      send_cmd(random_stim());
    end
    wait_all_done();

    // quiet window so stray pulses after the last command are seen
    repeat (10) @(negedge clk);
    check_idle_outputs("after the last command");
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                  clk,
  input  logic                  rst,
  input  opfetch_pkg::mem_req_t mem_req,
  input  logic                  load_en,
  input  logic [3:0]            load_addr,
  input  logic [31:0]           load_data,
  output logic [31:0]           rdata,
  output logic                  read_dn,
  output logic                  write_dn,
  output logic [15:0][31:0]     image
);

  logic [15:0][31:0] mem;
  logic              busy;
  logic              is_write;
  logic [3:0]        addr_q;
  logic [31:0]       wdata_q;
  logic [1:0]        delay;

  assign image = mem;

  initial begin
    rdata = '0;
    read_dn = 1'b0;
    write_dn = 1'b0;
  end

  // one request at a time answered 1 to 4 cycles later
  always @(posedge clk) begin
    read_dn <= 1'b0;
    write_dn <= 1'b0;
    // preload port for use while the DUT is idle
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    if (rst) begin
      busy <= 1'b0;
      rdata <= '0;
    end else if (busy) begin
      if (delay == 2'd0) begin
        busy <= 1'b0;
        if (is_write) begin
          mem[addr_q] <= wdata_q;
          write_dn <= 1'b1;
        end else begin
          rdata <= mem[addr_q];
          read_dn <= 1'b1;
        end
      end else begin
        delay <= delay - 2'd1;
      end
    end else if (mem_req.read || mem_req.write) begin
      busy <= 1'b1;
      is_write <= mem_req.write;
      // only 16 words so upper address bits wrap
      addr_q <= mem_req.addr[3:0];
      wdata_q <= mem_req.wdata;
      delay <= 2'($urandom_range(3, 0));
    end
  end

endmodule

//--- src/opfetch_top.sv
`timescale 1ns/1ps

module opfetch_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_valid,
  input  logic [31:0]                    cmd_word,
  input  logic [opfetch_pkg::data_w-1:0] cmd_ip,
  input  logic [opfetch_pkg::data_w-1:0] dst_value,
  output logic                           cmd_ready,
  output opfetch_pkg::mem_req_t          mem_req,
  input  logic [opfetch_pkg::data_w-1:0] rdata,
  input  logic                           read_dn,
  input  logic                           write_dn,
  output opfetch_pkg::operands_t         operands,
  output logic                           ops_valid,
  output logic                           done
);

  import opfetch_pkg::*;

  cmd_t     cmd;
  logic     dec_valid;
  logic     fetch_take;
  mem_req_t fetch_req;
  fetched_t fetched;
  logic     fetch_valid;
  wb_set_t  wb_set;
  logic     upd_valid;
  logic     wb_busy;

  cmd_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .cmd_ip     (cmd_ip),
    .dst_value  (dst_value),
    .fetch_take (fetch_take),
    .cmd_ready  (cmd_ready),
    .dec_valid  (dec_valid),
    .cmd        (cmd)
  );

  operand_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .cmd         (cmd),
    .wb_busy     (wb_busy),
    .rdata       (rdata),
    .read_dn     (read_dn),
    .fetch_take  (fetch_take),
    .fetch_req   (fetch_req),
    .ops_valid   (ops_valid),
    .operands    (operands),
    .fetch_valid (fetch_valid),
    .fetched     (fetched)
  );

  operand_update u_update (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetched     (fetched),
    .upd_valid   (upd_valid),
    .wb_set      (wb_set)
  );

  mem_writeback u_writeback (
    .clk       (clk),
    .rst       (rst),
    .upd_valid (upd_valid),
    .wb_set    (wb_set),
    .fetch_req (fetch_req),
    .write_dn  (write_dn),
    .wb_busy   (wb_busy),
    .mem_req   (mem_req),
    .done      (done)
  );

endmodule

//--- src/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  upd_valid,
  input  opfetch_pkg::wb_set_t  wb_set,
  input  opfetch_pkg::mem_req_t fetch_req,
  input  logic                  write_dn,
  output logic                  wb_busy,
  output opfetch_pkg::mem_req_t mem_req,
  output logic                  done
);

  import opfetch_pkg::*;

  wb_state_e         state;
  wb_set_t           pend;
  // bit 0 is dst, then cond, src1, src0
  logic [3:0]        left;
  logic              have_next;
  logic [1:0]        next_idx;
  wb_item_t          pick;
  logic              wr_write;
  logic [data_w-1:0] wr_addr;
  logic [data_w-1:0] wr_data;
  mem_req_t          wr_req;

  // lowest pending entry wins
  always_comb begin
    have_next = 1'b0;
    next_idx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (left[i]) begin
        have_next = 1'b1;
        next_idx = 2'(i);
      end
    end
  end

  always_comb begin
    case (next_idx)
      2'd0: pick = pend.dst;
      2'd1: pick = pend.cond;
      2'd2: pick = pend.src1;
      default: pick = pend.src0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wb_idle;
      left <= 4'd0;
      wr_write <= 1'b0;
    end else begin
      wr_write <= 1'b0;
      case (state)
        wb_idle: begin
          if (upd_valid) begin
            left <= {wb_set.src0.valid, wb_set.src1.valid, wb_set.cond.valid,
                     wb_set.dst.valid};
            state <= wb_next;
          end
        end
        wb_next: begin
          if (have_next) begin
            wr_write <= 1'b1;
            left[next_idx] <= 1'b0;
            state <= wb_wait;
          end else begin
            state <= wb_idle;
          end
        end
        wb_wait: begin
          if (write_dn) begin
            state <= wb_next;
          end
        end
        default: state <= wb_idle;
      endcase
    end
  end

  // address and data held until write_dn
  always_ff @(posedge clk) begin
    if (state == wb_idle && upd_valid) begin
      pend <= wb_set;
    end
    if (state == wb_next && have_next) begin
      wr_addr <= data_w'(pick.reg_num);
      wr_data <= pick.data;
    end
  end

  assign wr_req.read = 1'b0;
  assign wr_req.write = wr_write;
  assign wr_req.addr = wr_addr;
  assign wr_req.wdata = wr_data;

  // fetch stage owns the port only while idle
  assign mem_req = (state == wb_idle) ? fetch_req : wr_req;

  assign wb_busy = (state != wb_idle);
  assign done = (state == wb_next) && !have_next;

endmodule

//--- src/operand_update.sv
`timescale 1ns/1ps

module operand_update (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_valid,
  input  opfetch_pkg::fetched_t fetched,
  output logic                  upd_valid,
  output opfetch_pkg::wb_set_t  wb_set
);

  import opfetch_pkg::*;

  logic [data_w-1:0] new_dst;
  wb_set_t           set_next;

  // operand entry, with aliasing onto the new dst value
  function automatic wb_item_t op_item(slot_t s, logic [data_w-1:0] val,
                                       logic [data_w-1:0] ea, slot_t d,
                                       logic [data_w-1:0] dst_new);
    wb_item_t          it;
    logic [data_w-1:0] cur_val;
    logic [data_w-1:0] base;
    cur_val = (s.reg_num == d.reg_num) ? dst_new : val;
    base = s.ptr ? ea : cur_val;
    it.valid = (s.mode == mode_inc) || (s.mode == mode_dec);
    it.reg_num = s.reg_num;
    it.data = (s.mode == mode_inc) ? base + 1'b1 : base - 1'b1;
    return it;
  endfunction

  always_comb begin
    case (fetched.cmd.dst.mode)
      mode_inc: new_dst = fetched.cmd.dst_value + 1'b1;
      mode_dec: new_dst = fetched.cmd.dst_value - 1'b1;
      default: new_dst = fetched.cmd.dst_value;
    endcase
  end

  always_comb begin
    set_next.dst.valid = (fetched.cmd.dst.mode != mode_keep);
    set_next.dst.reg_num = fetched.cmd.dst.reg_num;
    set_next.dst.data = new_dst;
    set_next.cond = op_item(fetched.cmd.cond, fetched.ops.cond, fetched.cond_ea,
                            fetched.cmd.dst, new_dst);
    set_next.src1 = op_item(fetched.cmd.src1, fetched.ops.src1, fetched.src1_ea,
                            fetched.cmd.dst, new_dst);
    set_next.src0 = op_item(fetched.cmd.src0, fetched.ops.src0, fetched.src0_ea,
                            fetched.cmd.dst, new_dst);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      upd_valid <= 1'b0;
    end else begin
      upd_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      wb_set <= set_next;
    end
  end

endmodule

//--- src/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           dec_valid,
  input  opfetch_pkg::cmd_t              cmd,
  input  logic                           wb_busy,
  input  logic [opfetch_pkg::data_w-1:0] rdata,
  input  logic                           read_dn,
  output logic                           fetch_take,
  output opfetch_pkg::mem_req_t          fetch_req,
  output logic                           ops_valid,
  output opfetch_pkg::operands_t         operands,
  output logic                           fetch_valid,
  output opfetch_pkg::fetched_t          fetched
);

  import opfetch_pkg::*;

  fetch_state_e      state;
  logic [1:0]        slot_idx;
  fetched_t          cur;
  slot_t             cur_slot;
  logic              req_read;
  logic [data_w-1:0] req_addr;
  logic              load_en;
  logic [data_w-1:0] load_val;
  logic [data_w-1:0] load_ea;

  // wb_busy low means earlier writes have landed
  assign fetch_take = (state == fs_idle) && dec_valid && !wb_busy;

  // slot order is cond, src1, src0
  always_comb begin
    case (slot_idx)
      2'd0: cur_slot = cur.cmd.cond;
      2'd1: cur_slot = cur.cmd.src1;
      default: cur_slot = cur.cmd.src0;
    endcase
  end

  // value to store for the current slot, and when
  always_comb begin
    load_en = 1'b0;
    load_val = rdata;
    load_ea = data_w'(cur_slot.reg_num);
    case (state)
      fs_direct: begin
        // ip register never goes to memory
        if (cur_slot.reg_num == ip_reg) begin
          load_en = 1'b1;
          load_val = cur.cmd.ip;
        end
      end
      fs_direct_wait: begin
        if (read_dn && !cur_slot.ptr) begin
          load_en = 1'b1;
        end else if (read_dn && rdata == data_w'(ip_reg)) begin
          load_en = 1'b1;
          load_val = cur.cmd.ip;
          load_ea = data_w'(ip_reg);
        end
      end
      fs_ptr_wait: begin
        if (read_dn) begin
          load_en = 1'b1;
          load_ea = req_addr;
        end
      end
      default: load_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fs_idle;
      slot_idx <= 2'd0;
      req_read <= 1'b0;
    end else begin
      req_read <= 1'b0;
      case (state)
        fs_idle: begin
          if (fetch_take) begin
            slot_idx <= 2'd0;
            state <= fs_direct;
          end
        end
        fs_direct: begin
          if (!load_en) begin
            req_read <= 1'b1;
            state <= fs_direct_wait;
          end
        end
        fs_direct_wait: begin
          // second read through the pointer
          if (read_dn && !load_en) begin
            req_read <= 1'b1;
            state <= fs_ptr_wait;
          end
        end
        // two idle cycles let wb_busy rise before the next take
        fs_done: state <= fs_drain;
        fs_drain: state <= fs_idle;
        default: state <= state;
      endcase
      if (load_en) begin
        if (slot_idx == 2'd2) begin
          state <= fs_done;
        end else begin
          slot_idx <= slot_idx + 2'd1;
          state <= fs_direct;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_take) begin
      cur.cmd <= cmd;
    end
    if (state == fs_direct) begin
      req_addr <= data_w'(cur_slot.reg_num);
    end else if (state == fs_direct_wait && read_dn) begin
      req_addr <= rdata;
    end
    if (load_en) begin
      case (slot_idx)
        2'd0: begin
          cur.ops.cond <= load_val;
          cur.cond_ea <= load_ea;
        end
        2'd1: begin
          cur.ops.src1 <= load_val;
          cur.src1_ea <= load_ea;
        end
        default: begin
          cur.ops.src0 <= load_val;
          cur.src0_ea <= load_ea;
        end
      endcase
    end
  end

  assign fetch_req.read = req_read;
  assign fetch_req.write = 1'b0;
  assign fetch_req.addr = req_addr;
  assign fetch_req.wdata = '0;

  assign ops_valid = (state == fs_done);
  assign fetch_valid = (state == fs_done);
  assign operands = cur.ops;
  assign fetched = cur;

endmodule

//--- src/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_valid,
  input  logic [31:0]                    cmd_word,
  input  logic [opfetch_pkg::data_w-1:0] cmd_ip,
  input  logic [opfetch_pkg::data_w-1:0] dst_value,
  input  logic                           fetch_take,
  output logic                           cmd_ready,
  output logic                           dec_valid,
  output opfetch_pkg::cmd_t              cmd
);

  import opfetch_pkg::*;

  cmd_t dec_next;

  function automatic slot_t get_slot(logic [31:0] w, int reg_pos, int ptr_pos, int mode_pos);
    slot_t s;
    s.reg_num = w[reg_pos +: reg_w];
    s.ptr = w[ptr_pos];
    s.mode = mode_e'(w[mode_pos +: mode_w]);
    return s;
  endfunction

  // split the word into the four slots
  always_comb begin
    dec_next.cond = get_slot(cmd_word, cond_reg_pos, cond_ptr_pos, cond_mode_pos);
    dec_next.src1 = get_slot(cmd_word, src1_reg_pos, src1_ptr_pos, src1_mode_pos);
    dec_next.src0 = get_slot(cmd_word, src0_reg_pos, src0_ptr_pos, src0_mode_pos);
    // dst pointer bit is carried along but has no effect downstream
    dec_next.dst = get_slot(cmd_word, dst_reg_pos, dst_ptr_pos, dst_mode_pos);
    dec_next.ip = cmd_ip;
    dec_next.dst_value = dst_value;
  end

  // single holding register
  assign cmd_ready = ~dec_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      dec_valid <= 1'b1;
    end else if (fetch_take) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd <= dec_next;
    end
  end

endmodule

//--- src/opfetch_pkg.sv
package opfetch_pkg;

  localparam int data_w = 32;
  localparam int reg_w = 4;
  localparam int mode_w = 2;
  localparam logic [reg_w-1:0] ip_reg = 4'd15;

  // command word field positions
  localparam int src1_reg_pos = 0;
  localparam int src0_reg_pos = 4;
  localparam int dst_reg_pos = 8;
  localparam int cond_reg_pos = 12;
  localparam int src1_ptr_pos = 16;
  localparam int src0_ptr_pos = 17;
  localparam int dst_ptr_pos = 18;
  localparam int cond_ptr_pos = 19;
  localparam int src1_mode_pos = 20;
  localparam int src0_mode_pos = 22;
  localparam int dst_mode_pos = 24;
  localparam int cond_mode_pos = 26;

  // keep on dst means no write, on operands none and keep both skip write-back
  typedef enum logic [mode_w-1:0] {
    mode_none = 2'b00,
    mode_inc  = 2'b01,
    mode_dec  = 2'b10,
    mode_keep = 2'b11
  } mode_e;

  typedef struct packed {
    logic [reg_w-1:0] reg_num;
    logic             ptr;
    mode_e            mode;
  } slot_t;

  typedef struct packed {
    slot_t             cond;
    slot_t             src1;
    slot_t             src0;
    slot_t             dst;
    logic [data_w-1:0] ip;
    logic [data_w-1:0] dst_value;
  } cmd_t;

  typedef struct packed {
    logic [data_w-1:0] cond;
    logic [data_w-1:0] src1;
    logic [data_w-1:0] src0;
  } operands_t;

  // ea is the register number, or the pointer value after indirection
  typedef struct packed {
    cmd_t              cmd;
    operands_t         ops;
    logic [data_w-1:0] cond_ea;
    logic [data_w-1:0] src1_ea;
    logic [data_w-1:0] src0_ea;
  } fetched_t;

  typedef struct packed {
    logic              valid;
    logic [reg_w-1:0]  reg_num;
    logic [data_w-1:0] data;
  } wb_item_t;

  // write order is dst first
  typedef struct packed {
    wb_item_t dst;
    wb_item_t cond;
    wb_item_t src1;
    wb_item_t src0;
  } wb_set_t;

  typedef struct packed {
    logic              read;
    logic              write;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    fs_idle,
    fs_direct,
    fs_direct_wait,
    fs_ptr_wait,
    fs_done,
    fs_drain
  } fetch_state_e;

  typedef enum logic [1:0] {
    wb_idle,
    wb_next,
    wb_wait
  } wb_state_e;

endpackage
